// ==== hw/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

//////////////////////////////////////////////////////////////////////
// fetch unit configuration
//////////////////////////////////////////////////////////////////////

// data and address width
`define FETCH_XLEN            32

// 16-bit parcels per memory word
`define FETCH_PARCELS         2

// program counter after reset
`define FETCH_PC_INIT         32'h0000_0200

// parcel queue capacity
`define FETCH_QUEUE_DEPTH     12

// stop requesting at this occupancy, rest is room for words in flight
`define FETCH_FULL_THRESHOLD  6

`endif

// ==== hw/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // basic types
  //////////////////////////////////////////////////////////////////////

  typedef logic [15:0]            parcel_t;  // one halfword from memory
  typedef logic [`FETCH_XLEN-1:0] instr_t;   // full 32-bit instruction word
  typedef logic [`FETCH_XLEN-1:0] addr_t;    // byte address

  // supported compressed opcodes, encoded as {funct3, quadrant}
  typedef enum logic [4:0] {
    C_ADDI = 5'b000_01,  // also C.NOP when rd is x0
    C_LI   = 5'b010_01,
    C_J    = 5'b101_01,
    C_CR   = 5'b100_10   // C.JR, C.MV, C.ADD (and the unsupported C.JALR)
  } rvc_opc_e;

  //////////////////////////////////////////////////////////////////////
  // full instruction words
  //////////////////////////////////////////////////////////////////////

  localparam instr_t OPC_NOP = 32'h0000_0013;  // addi x0,x0,0
  localparam instr_t OPC_WFI = 32'h1050_0073;

  // major opcodes, bits [6:0]
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;

endpackage

// ==== hw/fetch_addr_gen.sv ====
`include "fetch_cfg.svh"

module fetch_addr_gen (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             flush_i,        // redirect strobe
  input  fetch_pkg::addr_t flush_pc_i,     // redirect target
  input  logic             almost_full_i,  // queue near capacity

  input  logic             imem_ack_i,
  output logic             imem_req_o,
  output fetch_pkg::addr_t imem_adr_o,
  output logic             imem_flush_o
);

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // only ask while there is room and no redirect is going on
  assign imem_req_o = ~almost_full_i & ~flush_i;

  // memory drops whatever is in flight on a redirect
  assign imem_flush_o = flush_i;

  //////////////////////////////////////////////////////////////////////
  // word address
  //////////////////////////////////////////////////////////////////////

  // linear stream of words, target is rounded down to a word
  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
      imem_adr_o <= `FETCH_PC_INIT;
    else if (flush_i)
      imem_adr_o <= {flush_pc_i[`FETCH_XLEN-1:2], 2'b00};  // halfword offset handled by queue
    else if (imem_req_o && imem_ack_i)
      imem_adr_o <= imem_adr_o + `FETCH_XLEN'(4);           // next word

endmodule

// ==== hw/parcel_queue.sv ====
`include "fetch_cfg.svh"

module parcel_queue (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  input  logic                         flush_i,
  input  logic                         drop_first_i,    // skip low parcel of next word

  input  fetch_pkg::instr_t            parcel_i,        // word from memory
  input  logic [`FETCH_PARCELS-1:0]    parcel_valid_i,  // one bit per parcel

  input  logic [1:0]                   rd_parcels_i,    // parcels consumed this cycle
  output fetch_pkg::parcel_t [1:0]     head_parcels_o,
  output logic [1:0]                   head_count_o,    // saturates at 2
  output logic                         almost_full_o
);
  import fetch_pkg::*;

  localparam int DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int CW    = $clog2(DEPTH + 1);

  parcel_t           q     [DEPTH];  // entry 0 is the head
  parcel_t           q_nxt [DEPTH];
  logic [CW-1:0]     count;
  logic [CW-1:0]     count_nxt;
  logic [CW-1:0]     keep;           // entries left after the read
  logic [1:0]        wr_valid;
  logic [1:0]        wr_cnt;
  parcel_t [1:0]     wr_data;        // valid parcels packed to the bottom

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // nothing is taken while flushing, stale data
  assign wr_valid = flush_i ? 2'b00
                            : {parcel_valid_i[1], parcel_valid_i[0] & ~drop_first_i};

  assign wr_data[0] = wr_valid[0] ? parcel_i[15:0] : parcel_i[31:16];
  assign wr_data[1] = parcel_i[31:16];
  assign wr_cnt     = {1'b0, wr_valid[0]} + {1'b0, wr_valid[1]};

  //////////////////////////////////////////////////////////////////////
  // shift and append
  //////////////////////////////////////////////////////////////////////

  assign keep      = count - CW'(rd_parcels_i);
  assign count_nxt = keep + CW'(wr_cnt);

  always_comb
  begin
    int src;
    int wr_idx;
    for (int i = 0; i < DEPTH; i++)
    begin
      src    = i + int'(rd_parcels_i);
      wr_idx = i - int'(keep);
      if (src < DEPTH)
        q_nxt[i] = q[src];  // shift down by the read count
      else
        q_nxt[i] = q[i];    // beyond occupancy, don't care
      if (wr_idx >= 0 && wr_idx < int'(wr_cnt))
        q_nxt[i] = wr_data[wr_idx[0]];  // append right after the kept ones
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
      count <= '0;
    else if (flush_i)
      count <= '0;       // empty on redirect
    else
      count <= count_nxt;

  always_ff @(posedge clk_i)
    q <= q_nxt;

  //////////////////////////////////////////////////////////////////////
  // head view
  //////////////////////////////////////////////////////////////////////

  assign head_parcels_o[0] = q[0];
  assign head_parcels_o[1] = q[1];
  assign head_count_o      = (count >= CW'(2)) ? 2'd2 : count[1:0];
  assign almost_full_o     = count >= CW'(`FETCH_FULL_THRESHOLD);

endmodule

// ==== hw/rvc_expander.sv ====
module rvc_expander (
  input  fetch_pkg::parcel_t [1:0] head_parcels_i,
  input  logic [1:0]               head_count_i,
  input  logic                     advance_i,     // output stage takes the insn
  output logic [1:0]               rd_parcels_o,  // pop count for the queue
  output fetch_pkg::instr_t        insn_o,
  output logic                     insn_valid_o,
  output logic                     insn_is16_o,
  output logic                     illegal_o
);
  import fetch_pkg::*;

  parcel_t     p0;
  parcel_t     p1;
  logic [4:0]  c_rd;    // rd/rs1 field of CI and CR
  logic [4:0]  c_rs2;   // rs2 field of CR
  logic [11:0] imm_ci;  // sign extended 6-bit immediate
  logic [20:1] imm_cj;  // C.J offset

  // I-type word with funct3 000
  function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, 3'b000, rd, opc};
  endfunction

  // add rd,rs1,rs2
  function automatic instr_t enc_add(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [4:0] rd);
    return {7'b000_0000, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // length and fields
  //////////////////////////////////////////////////////////////////////

  assign p0          = head_parcels_i[0];
  assign p1          = head_parcels_i[1];
  assign insn_is16_o = p0[1:0] != 2'b11;
  assign insn_valid_o = insn_is16_o ? (head_count_i != 2'd0)
                                    : (head_count_i >= 2'd2);  // both halves present

  assign rd_parcels_o = !advance_i  ? 2'd0 :
                        insn_is16_o ? 2'd1 : 2'd2;

  assign c_rd   = p0[11:7];
  assign c_rs2  = p0[6:2];
  assign imm_ci = {{6{p0[12]}}, p0[12], p0[6:2]};
  assign imm_cj = {{9{p0[12]}}, p0[12], p0[8], p0[10:9], p0[6], p0[7], p0[2],
                   p0[11], p0[5:3]};

  //////////////////////////////////////////////////////////////////////
  // expansion
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    illegal_o = 1'b0;
    insn_o    = OPC_NOP;
    if (insn_is16_o)
    begin
      case ({p0[15:13], p0[1:0]})
        C_ADDI : insn_o = (c_rd == 5'd0) ? OPC_NOP                      // C.NOP and hints
                                         : enc_i(imm_ci, c_rd, c_rd, OPC_OP_IMM);
        C_LI   : insn_o = enc_i(imm_ci, 5'd0, c_rd, OPC_OP_IMM);      // addi rd,x0,imm
        C_J    : insn_o = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12],
                           5'd0, OPC_JAL};                             // jal x0,imm
        C_CR   :
        begin
          if (c_rs2 != 5'd0)
            insn_o = enc_add(c_rs2, p0[12] ? c_rd : 5'd0, c_rd);      // C.ADD / C.MV
          else if (!p0[12] && c_rd != 5'd0)
            insn_o = enc_i(12'd0, c_rd, 5'd0, OPC_JALR);              // C.JR
          else
            illegal_o = 1'b1;  // reserved, C.JALR, C.EBREAK
        end
        default : illegal_o = 1'b1;  // incl. the all-zero parcel
      endcase
      if (illegal_o)
        insn_o = {16'h0000, p0};  // raw parcel for the trap handler
    end
    else if ({p1, p0} == OPC_WFI)
      insn_o = OPC_NOP;           // wfi runs as a nop
    else
      insn_o = {p1, p0};
  end

endmodule

// ==== hw/fetch_output_stage.sv ====
`include "fetch_cfg.svh"

module fetch_output_stage (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              flush_i,
  input  fetch_pkg::addr_t  flush_pc_i,
  input  logic              stall_i,        // pre-decode holds

  input  fetch_pkg::instr_t insn_i,
  input  logic              insn_valid_i,
  input  logic              insn_is16_i,
  input  logic              illegal_i,
  output logic              advance_o,      // head instruction consumed

  output fetch_pkg::instr_t insn_o,
  output fetch_pkg::addr_t  pc_o,
  output logic              insn_bubble_o,
  output logic              insn_illegal_o
);
  import fetch_pkg::*;

  addr_t nxt_pc;  // pc of the instruction at the queue head

  assign advance_o = insn_valid_i & ~stall_i & ~flush_i;

  //////////////////////////////////////////////////////////////////////
  // next pc
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
      nxt_pc <= `FETCH_PC_INIT;
    else if (flush_i)
      nxt_pc <= {flush_pc_i[`FETCH_XLEN-1:1], 1'b0};
    else if (advance_o)
      nxt_pc <= nxt_pc + (insn_is16_i ? `FETCH_XLEN'(2) : `FETCH_XLEN'(4));

  //////////////////////////////////////////////////////////////////////
  // registered outputs
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      pc_o           <= `FETCH_PC_INIT;
      insn_bubble_o  <= 1'b1;
      insn_illegal_o <= 1'b0;
    end
    else if (flush_i)
    begin
      insn_bubble_o  <= 1'b1;  // kill whatever sits here, even under stall
      insn_illegal_o <= 1'b0;
    end
    else if (!stall_i)
    begin
      pc_o           <= nxt_pc;
      insn_bubble_o  <= ~advance_o;
      insn_illegal_o <= advance_o & illegal_i;
    end

  always_ff @(posedge clk_i)
    if (!stall_i)
      insn_o <= insn_i;

endmodule

// ==== hw/insn_fetch_top.sv ====
`include "fetch_cfg.svh"

module insn_fetch_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // instruction memory
  output fetch_pkg::addr_t          imem_adr_o,
  output logic                      imem_req_o,
  input  logic                      imem_ack_i,
  output logic                      imem_flush_o,
  input  fetch_pkg::instr_t         imem_parcel_i,
  input  logic [`FETCH_PARCELS-1:0] imem_parcel_valid_i,

  // redirect and back-pressure
  input  logic                      flush_i,
  input  fetch_pkg::addr_t          flush_pc_i,
  input  logic                      stall_i,

  // towards pre-decode
  output fetch_pkg::instr_t         insn_o,
  output fetch_pkg::addr_t          pc_o,
  output logic                      insn_bubble_o,
  output logic                      insn_illegal_o
);
  import fetch_pkg::*;

  parcel_t [1:0] head_parcels;
  logic [1:0]    head_count;
  logic [1:0]    rd_parcels;
  logic          almost_full;
  instr_t        insn;
  logic          insn_valid;
  logic          insn_is16;
  logic          illegal;
  logic          advance;
  logic          drop_first;  // target was halfword aligned

  //////////////////////////////////////////////////////////////////////
  // halfword redirect marker
  //////////////////////////////////////////////////////////////////////

  // cleared by the first word that makes it into the queue
  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
      drop_first <= 1'b0;
    else if (flush_i)
      drop_first <= flush_pc_i[1];
    else if (|imem_parcel_valid_i)
      drop_first <= 1'b0;

  //////////////////////////////////////////////////////////////////////
  // fetch chain
  //////////////////////////////////////////////////////////////////////

  fetch_addr_gen u_addr_gen (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .flush_i       ( flush_i      ),
    .flush_pc_i    ( flush_pc_i   ),
    .almost_full_i ( almost_full  ),
    .imem_ack_i    ( imem_ack_i   ),
    .imem_req_o    ( imem_req_o   ),
    .imem_adr_o    ( imem_adr_o   ),
    .imem_flush_o  ( imem_flush_o )
  );

  parcel_queue u_queue (
    .clk_i          ( clk_i               ),
    .rst_ni         ( rst_ni              ),
    .flush_i        ( flush_i             ),
    .drop_first_i   ( drop_first          ),
    .parcel_i       ( imem_parcel_i       ),
    .parcel_valid_i ( imem_parcel_valid_i ),
    .rd_parcels_i   ( rd_parcels          ),
    .head_parcels_o ( head_parcels        ),
    .head_count_o   ( head_count          ),
    .almost_full_o  ( almost_full         )
  );

  rvc_expander u_expander (
    .head_parcels_i ( head_parcels ),
    .head_count_i   ( head_count   ),
    .advance_i      ( advance      ),
    .rd_parcels_o   ( rd_parcels   ),
    .insn_o         ( insn         ),
    .insn_valid_o   ( insn_valid   ),
    .insn_is16_o    ( insn_is16    ),
    .illegal_o      ( illegal      )
  );

  fetch_output_stage u_out (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .flush_i        ( flush_i        ),
    .flush_pc_i     ( flush_pc_i     ),
    .stall_i        ( stall_i        ),
    .insn_i         ( insn           ),
    .insn_valid_i   ( insn_valid     ),
    .insn_is16_i    ( insn_is16      ),
    .illegal_i      ( illegal        ),
    .advance_o      ( advance        ),
    .insn_o         ( insn_o         ),
    .pc_o           ( pc_o           ),
    .insn_bubble_o  ( insn_bubble_o  ),
    .insn_illegal_o ( insn_illegal_o )
  );

endmodule

// ==== tests/insn_fetch_props.sv ====
module insn_fetch_props (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             imem_req_o,
  input  logic             insn_bubble_o,
  input  logic             insn_illegal_o,
  input  fetch_pkg::addr_t pc_o
);

  // no new fetch while redirecting
  req_during_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> !imem_req_o)
    else $error("imem_req_o high during flush_i");

  // illegal flag only rides on a real instruction
  illegal_on_bubble: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_illegal_o |-> !insn_bubble_o)
    else $error("insn_illegal_o high on a bubble");

  pc_even: assert property (@(posedge clk_i) disable iff (!rst_ni) !pc_o[0])
    else $error("pc_o is odd");

endmodule

bind insn_fetch_top insn_fetch_props props_i (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .flush_i        ( flush_i        ),
  .imem_req_o     ( imem_req_o     ),
  .insn_bubble_o  ( insn_bubble_o  ),
  .insn_illegal_o ( insn_illegal_o ),
  .pc_o           ( pc_o           )
);

// ==== tests/insn_fetch_tb.sv ====
`include "fetch_cfg.svh"

module insn_fetch_tb;

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] imem_adr_o;
  logic        imem_req_o;
  logic        imem_ack_i;
  logic        imem_flush_o;
  logic [31:0] imem_parcel_i;
  logic [1:0]  imem_parcel_valid_i;
  logic        flush_i;
  logic [31:0] flush_pc_i;
  logic        stall_i;
  logic [31:0] insn_o;
  logic [31:0] pc_o;
  logic        insn_bubble_o;
  logic        insn_illegal_o;

  logic [31:0] mem [0:255];     // program, word indexed
  logic [15:0] lfsr = 16'd40113;
  logic        take;
  logic        bit0;
  logic [31:0] take_adr;
  int          errors = 0;
  int          tests  = 0;
  logic [31:0] exp_insn [$];    // expected stream
  logic [31:0] exp_pc   [$];
  logic        exp_ill  [$];

  insn_fetch_top dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // reference encoder
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, 3'b000, rd, opc};
  endfunction

  function automatic logic [31:0] r_add(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {7'd0, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic logic [31:0] jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};  // rd x0
  endfunction

  // compressed forms, built from field layout
  function automatic logic [15:0] c_i(input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [5:0] imm);
    return {f3, imm[5], rd, imm[4:0], 2'b01};
  endfunction

  function automatic logic [15:0] c_r(input logic b12, input logic [4:0] rd,
                                      input logic [4:0] rs2);
    return {3'b100, b12, rd, rs2, 2'b10};
  endfunction

  function automatic logic [15:0] c_j(input logic [11:0] o);
    return {3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // galois, x16+x14+x13+x11+1
  endfunction

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  task automatic put16(input logic [31:0] a, input logic [15:0] p);
    if (a[1])
      mem[a[9:2]][31:16] = p;
    else
      mem[a[9:2]][15:0] = p;
  endtask

  // one word per accepted request, back a cycle later
  always @(posedge clk_i)
  begin
    take     = rst_ni && imem_req_o && imem_ack_i && !imem_flush_o;
    take_adr = imem_adr_o;
    #5;
    imem_parcel_valid_i = take ? 2'b11 : 2'b00;
    imem_parcel_i       = take ? mem[take_adr[9:2]] : 32'd0;
    lfsr       = lfsr_step(lfsr);
    bit0       = lfsr[0];
    lfsr       = lfsr_step(lfsr);
    imem_ack_i = !(bit0 && lfsr[0]);  // quarter of cycles held back
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic expect_insn(input logic [31:0] i, input logic [31:0] pc, input logic ill);
    exp_insn.push_back(i);
    exp_pc.push_back(pc);
    exp_ill.push_back(ill);
  endtask

  task automatic redirect(input logic [31:0] pc);
    exp_insn.delete();
    exp_pc.delete();
    exp_ill.delete();
    @(posedge clk_i);
    #5 flush_i = 1'b1;
    flush_pc_i = pc;
    @(negedge clk_i);
    if (imem_flush_o !== 1'b1)
    begin
      $display("Error at %0t: imem_flush_o is %b, expected 1", $time, imem_flush_o);
      errors++;
    end
    @(posedge clk_i);
    #5 flush_i = 1'b0;
    if (imem_adr_o !== {pc[31:2], 2'b00})  // word holding the target
    begin
      $display("Error at %0t: imem_adr_o is %h, expected %h", $time, imem_adr_o,
               {pc[31:2], 2'b00});
      errors++;
    end
  endtask

  // compare current output with the expected head and pop it
  task automatic compare_head();
    if (insn_o !== exp_insn[0])
    begin
      $display("Error at %0t: insn_o is %h, expected %h", $time, insn_o, exp_insn[0]);
      errors++;
    end
    if (pc_o !== exp_pc[0])
    begin
      $display("Error at %0t: pc_o is %h, expected %h", $time, pc_o, exp_pc[0]);
      errors++;
    end
    if (insn_illegal_o !== exp_ill[0])
    begin
      $display("Error at %0t: insn_illegal_o is %b, expected %b", $time, insn_illegal_o,
               exp_ill[0]);
      errors++;
    end
    void'(exp_insn.pop_front());
    void'(exp_pc.pop_front());
    void'(exp_ill.pop_front());
  endtask

  // wait for n instructions, sampled at the falling edge
  task automatic check_stream(input int n);
    int wait_cnt;
    for (int k = 0; k < n; k++)
    begin
      wait_cnt = 0;
      do
      begin
        @(negedge clk_i);
        wait_cnt++;
      end
      while (insn_bubble_o && wait_cnt < 100);
      if (insn_bubble_o)
      begin
        $display("no instruction came out within 100 cycles at %0t", $time);
        errors++;
        return;
      end
      compare_head();
    end
  endtask

  task automatic report(input string name);
    tests++;
    $display("test %s done, %0d errors so far", name, errors);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int n;
    @(negedge clk_i);
    if (insn_bubble_o !== 1'b1 || imem_flush_o !== 1'b0 || insn_illegal_o !== 1'b0)
    begin
      $display("Error at %0t: reset outputs bubble %b flush %b illegal %b, expected 1 0 0",
               $time, insn_bubble_o, imem_flush_o, insn_illegal_o);
      errors++;
    end
    n = 0;
    while (!(imem_req_o && imem_ack_i) && n < 50)
    begin
      @(negedge clk_i);  // handshake is taken at the next rising edge
      n++;
    end
    if (!(imem_req_o && imem_ack_i))
    begin
      $display("no request was accepted within 50 cycles after reset");
      errors++;
    end
    else if (imem_adr_o !== `FETCH_PC_INIT)
    begin
      $display("Error at %0t: imem_adr_o is %h, expected %h", $time, imem_adr_o,
               `FETCH_PC_INIT);
      errors++;
    end
    report("reset");
  endtask

  task automatic add_run32();
    expect_insn(i_type(12'd1, 5'd0, 5'd1, 7'h13), 32'h200, 1'b0);
    expect_insn(i_type(12'd2, 5'd1, 5'd2, 7'h13), 32'h204, 1'b0);
    expect_insn(32'h0000_0013, 32'h208, 1'b0);                     // wfi as nop
    expect_insn(r_add(5'd3, 5'd1, 5'd2), 32'h20c, 1'b0);
    expect_insn(i_type(12'h210, 5'd0, 5'd5, 7'h13), 32'h210, 1'b0);  // fill word
    expect_insn(i_type(12'h214, 5'd0, 5'd5, 7'h13), 32'h214, 1'b0);
  endtask

  task automatic test_run32();
    redirect(32'h200);
    add_run32();
    check_stream(6);
    report("run32");
  endtask

  task automatic test_mixed();
    redirect(32'h240);
    expect_insn(i_type(12'd5, 5'd0, 5'd8, 7'h13), 32'h240, 1'b0);
    expect_insn(i_type(12'hfff, 5'd8, 5'd8, 7'h13), 32'h242, 1'b0);
    expect_insn(r_add(5'd9, 5'd0, 5'd8), 32'h244, 1'b0);
    expect_insn(r_add(5'd10, 5'd8, 5'd9), 32'h246, 1'b0);  // split over two words
    expect_insn(jal(21'd8), 32'h24a, 1'b0);
    expect_insn(i_type(12'd0, 5'd1, 5'd0, 7'h67), 32'h24c, 1'b0);
    expect_insn(r_add(5'd9, 5'd9, 5'd8), 32'h24e, 1'b0);
    expect_insn(32'h0000_0013, 32'h250, 1'b0);
    expect_insn(jal(21'h1f_fffc), 32'h252, 1'b0);
    check_stream(9);
    report("mixed");
  endtask

  task automatic test_illegal();
    redirect(32'h260);
    expect_insn(32'h0000_0000, 32'h260, 1'b1);
    expect_insn(32'h0000_4188, 32'h262, 1'b1);  // quadrant 0 load, not supported
    expect_insn(32'h0000_0013, 32'h264, 1'b0);
    expect_insn(i_type(12'hffe, 5'd0, 5'd1, 7'h13), 32'h266, 1'b0);
    check_stream(4);
    report("illegal");
  endtask

  task automatic test_redirect();
    redirect(32'h200);
    add_run32();
    check_stream(1);
    redirect(32'h262);  // halfword target, mid stream
    expect_insn(32'h0000_4188, 32'h262, 1'b1);
    expect_insn(32'h0000_0013, 32'h264, 1'b0);
    expect_insn(i_type(12'hffe, 5'd0, 5'd1, 7'h13), 32'h266, 1'b0);
    check_stream(3);
    report("redirect");
  endtask

  task automatic test_stall();
    logic [31:0] s_insn;
    logic [31:0] s_pc;
    logic        s_bub;
    logic        req_low;
    redirect(32'h200);
    add_run32();
    check_stream(1);
    @(posedge clk_i);
    #5 stall_i = 1'b1;
    @(negedge clk_i);
    s_insn  = insn_o;
    s_pc    = pc_o;
    s_bub   = insn_bubble_o;
    req_low = 1'b0;
    if (!s_bub)
      compare_head();  // already delivered before the hold
    repeat (30)
    begin
      @(negedge clk_i);
      if (insn_o !== s_insn)
      begin
        $display("Error at %0t: insn_o is %h under stall, expected %h", $time, insn_o,
                 s_insn);
        errors++;
      end
      if (pc_o !== s_pc)
      begin
        $display("Error at %0t: pc_o is %h under stall, expected %h", $time, pc_o, s_pc);
        errors++;
      end
      if (insn_bubble_o !== s_bub)
      begin
        $display("Error at %0t: insn_bubble_o is %b under stall, expected %b", $time,
                 insn_bubble_o, s_bub);
        errors++;
      end
      if (!imem_req_o)
        req_low = 1'b1;
    end
    if (!req_low)
    begin
      $display("imem_req_o never fell during a 30 cycle stall");
      errors++;
    end
    @(posedge clk_i);
    #5 stall_i = 1'b0;
    @(posedge clk_i);  // first edge that registers again
    check_stream(exp_insn.size());
    report("stall");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main flow and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    #((5 + 6 * 300) * 40);  // six tests, well under 300 cycles each
    $display("watchdog expired at %0t, run did not finish", $time);
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    rst_ni              = 1'b0;
    imem_ack_i          = 1'b0;
    imem_parcel_i       = 32'd0;
    imem_parcel_valid_i = 2'b00;
    flush_i             = 1'b0;
    flush_pc_i          = 32'd0;
    stall_i             = 1'b0;
    for (int i = 0; i < 256; i++)
      mem[i] = i_type(12'(i * 4), 5'd0, 5'd5, 7'h13);  // addi x5,x0,addr
    mem[8'h80] = i_type(12'd1, 5'd0, 5'd1, 7'h13);     // 0x200
    mem[8'h81] = i_type(12'd2, 5'd1, 5'd2, 7'h13);
    mem[8'h82] = 32'h1050_0073;                        // wfi
    mem[8'h83] = r_add(5'd3, 5'd1, 5'd2);
    put16(32'h240, c_i(3'b010, 5'd8, 6'd5));           // c.li x8,5
    put16(32'h242, c_i(3'b000, 5'd8, 6'h3f));          // c.addi x8,-1
    put16(32'h244, c_r(1'b0, 5'd9, 5'd8));             // c.mv x9,x8
    put16(32'h246, 16'(r_add(5'd10, 5'd8, 5'd9)));
    put16(32'h248, 16'(r_add(5'd10, 5'd8, 5'd9) >> 16));
    put16(32'h24a, c_j(12'd8));
    put16(32'h24c, c_r(1'b0, 5'd1, 5'd0));             // c.jr x1
    put16(32'h24e, c_r(1'b1, 5'd9, 5'd8));             // c.add x9,x8
    put16(32'h250, 16'h0001);                          // c.nop
    put16(32'h252, c_j(12'hffc));
    put16(32'h260, 16'h0000);
    put16(32'h262, 16'h4188);
    put16(32'h264, 16'h0001);
    put16(32'h266, c_i(3'b010, 5'd1, 6'h3e));          // c.li x1,-2
    repeat (5) @(posedge clk_i);
    #5 rst_ni = 1'b1;

    test_reset();
    test_run32();
    test_mixed();
    test_illegal();
    test_redirect();
    test_stall();

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== insn_fetch_top.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_addr_gen.sv
hw/parcel_queue.sv
hw/rvc_expander.sv
hw/fetch_output_stage.sv
hw/insn_fetch_top.sv
tests/insn_fetch_props.sv
tests/insn_fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall -Wno-fatal
TOP       ?= insn_fetch_tb
FILELIST  ?= insn_fetch_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
